//--- include/fe_cfg.svh
// ============================================================
// Width and size macros for the instruction front end
// Included by the package and by every module that needs them
// ============================================================
`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// Virtual address and instruction widths
`define FE_VADDR_W 32
`define FE_INSTR_W 32

// Direct-mapped cache with one instruction word per set
`define FE_SETS  16
`define FE_IDX_W 4

// Tag holds the address bits above the index and the 2 byte-offset bits
`define FE_TAG_W (`FE_VADDR_W - `FE_IDX_W - 2)

`endif

//--- project.f
+incdir+include
src/fe_pkg.sv
src/icache_arbiter.sv
src/icache_mem.sv
src/fe_fence_sweep.sv
src/fe_cmd_unit.sv
src/fe_fetch_pipe.sv
src/fe_top.sv
test/fe_checker.sv
test/fe_tb.sv

//--- run.sh
#!/bin/sh
# Builds the front end testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module fe_tb -f project.f -o fe_tb_sim

status=0
./obj_dir/fe_tb_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "Simulation FAILED" sim.log; then
  echo "run.sh: simulation reported a failure"
  exit 1
fi
echo "run.sh: simulation finished cleanly"

//--- src/fe_cmd_unit.sv
// ============================================================
// Command decode and the wait/run/stall controller
// Takes back end commands, writes fills and steers the fetch pipe
// ============================================================
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fe_cmd_unit
  import fe_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  fe_cmd_s                cmd_i,
  input  logic                   cmd_v_i,
  output logic                   cmd_yumi_o,
  input  logic                   queue_ready_i,
  input  logic [`FE_VADDR_W-1:0] resume_pc_i,
  input  logic                   fetch_fail_i,
  input  logic                   exc_sent_i,
  input  logic                   sweep_busy_i,
  output logic                   fence_start_o,
  output logic                   redirect_v_o,
  output logic [`FE_VADDR_W-1:0] redirect_pc_o,
  output logic                   run_o,
  output logic                   flush_o,
  output mem_req_s               fill_req_o,
  output logic                   fill_req_v_o,
  input  logic                   fill_gnt_i
);

  fe_state_e              state_r;
  fe_state_e              state_n;
  logic [`FE_VADDR_W-1:0] resume_r;
  logic                   is_redirect;
  logic                   is_fill;
  logic                   is_fence;
  logic                   is_wait;
  logic                   take_immediate;
  logic                   take_fence;
  logic                   take_wait;
  logic                   unstall;

  assign is_redirect = cmd_v_i & (cmd_i.opcode == e_op_redirect);
  assign is_fill     = cmd_v_i & (cmd_i.opcode == e_op_fill);
  assign is_fence    = cmd_v_i & (cmd_i.opcode == e_op_fence);
  assign is_wait     = cmd_v_i & (cmd_i.opcode == e_op_wait);

  // A fill is accepted in the same cycle its cache write wins the port
  assign cmd_yumi_o     = cmd_v_i & ~sweep_busy_i & (~is_fill | fill_gnt_i);
  assign take_immediate = cmd_yumi_o & (is_redirect | is_fill);
  assign take_fence     = cmd_yumi_o & is_fence;
  assign take_wait      = cmd_yumi_o & is_wait;

  assign fill_req_v_o = is_fill & ~sweep_busy_i;
  assign fill_req_o   = addr_req(e_mem_write, cmd_i.vaddr, cmd_i.instr);

  // Leave stall once the sweep is done and the queue can take a message
  assign unstall = (state_r == e_stall) & ~sweep_busy_i & queue_ready_i & ~cmd_v_i;

  assign redirect_v_o  = take_immediate | unstall;
  assign redirect_pc_o = take_immediate ? cmd_i.vaddr : resume_r;
  assign flush_o       = take_fence | take_wait;
  assign fence_start_o = take_fence;
  assign run_o         = (state_r == e_run);

  always_comb
  begin
    state_n = state_r;
    if (take_immediate)
      state_n = e_run;
    else if (take_fence)
      state_n = e_stall;
    else if (take_wait)
      state_n = e_wait;
    else
    begin
      case (state_r)
        e_run:
        begin
          // A dropped result outranks a delivered exception
          if (fetch_fail_i)
            state_n = e_stall;
          else if (exc_sent_i)
            state_n = e_wait;
        end
        e_stall:
        begin
          if (unstall)
            state_n = e_run;
        end
        e_wait:
          state_n = e_wait;
        default:
          state_n = e_wait;
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r  <= e_wait;
      resume_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      // While running, track the oldest fetch that has not retired
      if (take_immediate)
        resume_r <= cmd_i.vaddr;
      else if (run_o)
        resume_r <= resume_pc_i;
    end
  end

  // Fill writes are only raised on behalf of a pending fill command
  assert property (@(posedge clk_i) disable iff (reset_i)
    fill_req_v_o |-> cmd_v_i && (cmd_i.opcode == e_op_fill));

endmodule

//--- src/fe_fence_sweep.sv
// ============================================================
// Cache fence sweeper, clears one valid bit per granted cycle
// ============================================================
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fe_fence_sweep
  import fe_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,
  input  logic     start_i,
  output logic     busy_o,
  output mem_req_s inv_req_o,
  output logic     inv_req_v_o,
  input  logic     inv_gnt_i
);

  localparam int unsigned last_set_lp = `FE_SETS - 1;

  logic [`FE_IDX_W-1:0] set_r;
  logic                 busy_r;
  logic                 last_set;

  assign last_set    = (set_r == last_set_lp[`FE_IDX_W-1:0]);
  assign busy_o      = busy_r;
  assign inv_req_v_o = busy_r;

  always_comb
  begin
    inv_req_o      = '0;
    inv_req_o.kind = e_mem_inval;
    inv_req_o.idx  = set_r;
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      busy_r <= 1'b0;
      set_r  <= '0;
    end
    else if (start_i)
    begin
      busy_r <= 1'b1;
      set_r  <= '0;
    end
    else if (busy_r && inv_gnt_i)
    begin
      set_r <= set_r + 1'b1;
      if (last_set)
        busy_r <= 1'b0;
    end
  end

  // The controller must not start a second fence mid-sweep
  assert property (@(posedge clk_i) disable iff (reset_i) start_i |-> !busy_o);

endmodule

//--- src/fe_fetch_pipe.sv
// ============================================================
// Pc generation and the two fetch stages
// Issues cache reads in run and forms fetch or exception messages
// ============================================================
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fe_fetch_pipe
  import fe_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   run_i,
  input  logic                   flush_i,
  input  logic                   redirect_v_i,
  input  logic [`FE_VADDR_W-1:0] redirect_pc_i,
  output mem_req_s               rd_req_o,
  output logic                   rd_req_v_o,
  input  logic                   rd_gnt_i,
  input  logic                   hit_i,
  input  logic [`FE_INSTR_W-1:0] rdata_i,
  input  logic                   queue_ready_i,
  output fe_queue_s              queue_o,
  output logic                   queue_v_o,
  output logic [`FE_VADDR_W-1:0] resume_pc_o,
  output logic                   fetch_fail_o,
  output logic                   exc_sent_o
);

  logic [`FE_VADDR_W-1:0] pc_r;
  logic                   v_if1;
  logic [`FE_VADDR_W-1:0] pc_if1;
  logic                   v_if2_r;
  logic [`FE_VADDR_W-1:0] pc_if2_r;
  logic                   cmd_kill;
  logic                   kill_if1;

  // IF1 is the cycle in which a read of the current pc wins the port
  assign rd_req_v_o = run_i;
  assign rd_req_o   = addr_req(e_mem_read, pc_r, '0);
  assign v_if1      = rd_req_v_o & rd_gnt_i;
  assign pc_if1     = pc_r;

  // A command taken this cycle discards the IF2 result
  assign cmd_kill = flush_i | redirect_v_i;

  assign queue_v_o    = v_if2_r & queue_ready_i & ~cmd_kill;
  assign fetch_fail_o = v_if2_r & ~queue_ready_i & ~cmd_kill;
  assign exc_sent_o   = queue_v_o & ~hit_i;

  // The younger fetch dies whenever IF2 does not retire as a fetch
  assign kill_if1 = cmd_kill | fetch_fail_o | exc_sent_o;

  assign resume_pc_o = v_if2_r ? pc_if2_r : pc_if1;

  always_comb
  begin
    queue_o    = '0;
    queue_o.pc = pc_if2_r;
    if (hit_i)
    begin
      queue_o.msg_type = e_msg_fetch;
      queue_o.instr    = rdata_i;
    end
    else
    begin
      queue_o.msg_type = e_msg_exception;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      pc_r    <= '0;
      v_if2_r <= 1'b0;
    end
    else
    begin
      if (redirect_v_i)
        pc_r <= redirect_pc_i;
      else if (v_if1)
        pc_r <= pc_r + 'd4;
      v_if2_r <= v_if1 & ~kill_if1;
    end
  end

  // IF2 keeps the pc of the read whose result arrives next
  always_ff @(posedge clk_i)
  begin
    if (v_if1)
      pc_if2_r <= pc_if1;
  end

  assert property (@(posedge clk_i) disable iff (reset_i)
    queue_v_o |-> queue_ready_i);

endmodule

//--- src/fe_pkg.sv
// ============================================================
// Enums and packed structs shared by the front end and its testbench
// ============================================================
`include "fe_cfg.svh"

package fe_pkg;

  typedef enum logic [1:0] {
    e_op_redirect = 2'd0,
    e_op_fill     = 2'd1,
    e_op_fence    = 2'd2,
    e_op_wait     = 2'd3
  } fe_opcode_e;

  typedef enum logic [1:0] {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

  typedef enum logic {
    e_msg_fetch     = 1'b0,
    e_msg_exception = 1'b1
  } fe_msg_type_e;

  typedef enum logic [1:0] {
    e_mem_read  = 2'd0,
    e_mem_write = 2'd1,
    e_mem_inval = 2'd2
  } mem_kind_e;

  // Instr is only meaningful for a fill
  typedef struct packed {
    fe_opcode_e             opcode;
    logic [`FE_VADDR_W-1:0] vaddr;
    logic [`FE_INSTR_W-1:0] instr;
  } fe_cmd_s;

  typedef struct packed {
    fe_msg_type_e           msg_type;
    logic [`FE_VADDR_W-1:0] pc;
    logic [`FE_INSTR_W-1:0] instr;
  } fe_queue_s;

  typedef struct packed {
    mem_kind_e              kind;
    logic [`FE_IDX_W-1:0]   idx;
    logic [`FE_TAG_W-1:0]   tag;
    logic [`FE_INSTR_W-1:0] data;
  } mem_req_s;

  // Splits a word address into cache index and tag
  function automatic mem_req_s addr_req(mem_kind_e kind,
                                        logic [`FE_VADDR_W-1:0] addr,
                                        logic [`FE_INSTR_W-1:0] data);
    mem_req_s req;
    req.kind = kind;
    req.idx  = addr[2 +: `FE_IDX_W];
    req.tag  = addr[`FE_VADDR_W-1 -: `FE_TAG_W];
    req.data = data;
    return req;
  endfunction

endpackage

//--- src/fe_top.sv
// ============================================================
// Front end top level, ties the three cache peers to the memory
// ============================================================
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fe_top
  import fe_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,
  input  fe_cmd_s   fe_cmd_i,
  input  logic      fe_cmd_v_i,
  output logic      fe_cmd_yumi_o,
  output fe_queue_s fe_queue_o,
  output logic      fe_queue_v_o,
  input  logic      fe_queue_ready_i
);

  logic [`FE_VADDR_W-1:0] resume_pc;
  logic                   fetch_fail;
  logic                   exc_sent;
  logic                   sweep_busy;
  logic                   fence_start;
  logic                   redirect_v;
  logic [`FE_VADDR_W-1:0] redirect_pc;
  logic                   run;
  logic                   flush;
  mem_req_s               fill_req;
  logic                   fill_req_v;
  logic                   fill_gnt;
  mem_req_s               inv_req;
  logic                   inv_req_v;
  logic                   inv_gnt;
  mem_req_s               rd_req;
  logic                   rd_req_v;
  logic                   rd_gnt;
  mem_req_s               mem_req;
  logic                   mem_v;
  logic                   hit;
  logic [`FE_INSTR_W-1:0] rdata;

  fe_cmd_unit cmd_unit (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd_i         (fe_cmd_i),
    .cmd_v_i       (fe_cmd_v_i),
    .cmd_yumi_o    (fe_cmd_yumi_o),
    .queue_ready_i (fe_queue_ready_i),
    .resume_pc_i   (resume_pc),
    .fetch_fail_i  (fetch_fail),
    .exc_sent_i    (exc_sent),
    .sweep_busy_i  (sweep_busy),
    .fence_start_o (fence_start),
    .redirect_v_o  (redirect_v),
    .redirect_pc_o (redirect_pc),
    .run_o         (run),
    .flush_o       (flush),
    .fill_req_o    (fill_req),
    .fill_req_v_o  (fill_req_v),
    .fill_gnt_i    (fill_gnt)
  );

  fe_fetch_pipe fetch_pipe (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .run_i         (run),
    .flush_i       (flush),
    .redirect_v_i  (redirect_v),
    .redirect_pc_i (redirect_pc),
    .rd_req_o      (rd_req),
    .rd_req_v_o    (rd_req_v),
    .rd_gnt_i      (rd_gnt),
    .hit_i         (hit),
    .rdata_i       (rdata),
    .queue_ready_i (fe_queue_ready_i),
    .queue_o       (fe_queue_o),
    .queue_v_o     (fe_queue_v_o),
    .resume_pc_o   (resume_pc),
    .fetch_fail_o  (fetch_fail),
    .exc_sent_o    (exc_sent)
  );

  fe_fence_sweep fence_sweep (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .start_i     (fence_start),
    .busy_o      (sweep_busy),
    .inv_req_o   (inv_req),
    .inv_req_v_o (inv_req_v),
    .inv_gnt_i   (inv_gnt)
  );

  icache_arbiter arbiter (
    .inv_req_i  (inv_req),
    .inv_v_i    (inv_req_v),
    .inv_gnt_o  (inv_gnt),
    .fill_req_i (fill_req),
    .fill_v_i   (fill_req_v),
    .fill_gnt_o (fill_gnt),
    .rd_req_i   (rd_req),
    .rd_v_i     (rd_req_v),
    .rd_gnt_o   (rd_gnt),
    .mem_req_o  (mem_req),
    .mem_v_o    (mem_v)
  );

  icache_mem mem (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .req_i   (mem_req),
    .req_v_i (mem_v),
    .hit_o   (hit),
    .rdata_o (rdata)
  );

endmodule

//--- src/icache_arbiter.sv
// ============================================================
// Fixed-priority arbiter for the single instruction cache port
// ============================================================
`timescale 1ns/1ps

module icache_arbiter
  import fe_pkg::*;
(
  input  mem_req_s inv_req_i,
  input  logic     inv_v_i,
  output logic     inv_gnt_o,
  input  mem_req_s fill_req_i,
  input  logic     fill_v_i,
  output logic     fill_gnt_o,
  input  mem_req_s rd_req_i,
  input  logic     rd_v_i,
  output logic     rd_gnt_o,
  output mem_req_s mem_req_o,
  output logic     mem_v_o
);

  // Sweeper first, then fill writes, then fetch reads
  assign inv_gnt_o  = inv_v_i;
  assign fill_gnt_o = fill_v_i & ~inv_v_i;
  assign rd_gnt_o   = rd_v_i & ~inv_v_i & ~fill_v_i;
  assign mem_v_o    = inv_v_i | fill_v_i | rd_v_i;

  always_comb
  begin
    if (inv_v_i)
      mem_req_o = inv_req_i;
    else if (fill_v_i)
      mem_req_o = fill_req_i;
    else
      mem_req_o = rd_req_i;
  end

  always_comb
  begin
    assert ($onehot0({inv_gnt_o, fill_gnt_o, rd_gnt_o}))
      else $error("icache_arbiter: more than one grant");
  end

endmodule

//--- src/icache_mem.sv
// ============================================================
// Direct-mapped instruction cache arrays with one shared port
// Writes land at the edge, reads return hit and data a cycle later
// ============================================================
`timescale 1ns/1ps
`include "fe_cfg.svh"

module icache_mem
  import fe_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  mem_req_s               req_i,
  input  logic                   req_v_i,
  output logic                   hit_o,
  output logic [`FE_INSTR_W-1:0] rdata_o
);

  logic [`FE_TAG_W-1:0]   tag_mem  [`FE_SETS];
  logic [`FE_INSTR_W-1:0] data_mem [`FE_SETS];
  logic [`FE_SETS-1:0]    valid_r;

  logic                   rd_valid_r;
  logic [`FE_TAG_W-1:0]   rd_tag_r;
  logic [`FE_TAG_W-1:0]   req_tag_r;
  logic [`FE_INSTR_W-1:0] rdata_r;
  logic                   is_read;
  logic                   is_write;
  logic                   is_inval;

  assign is_read  = req_v_i & (req_i.kind == e_mem_read);
  assign is_write = req_v_i & (req_i.kind == e_mem_write);
  assign is_inval = req_v_i & (req_i.kind == e_mem_inval);

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      valid_r <= '0;
    else if (is_write)
      valid_r[req_i.idx] <= 1'b1;
    else if (is_inval)
      valid_r[req_i.idx] <= 1'b0;
  end

  always_ff @(posedge clk_i)
  begin
    if (is_write)
    begin
      tag_mem[req_i.idx]  <= req_i.tag;
      data_mem[req_i.idx] <= req_i.data;
    end
    if (is_read)
    begin
      rd_valid_r <= valid_r[req_i.idx];
      rd_tag_r   <= tag_mem[req_i.idx];
      req_tag_r  <= req_i.tag;
      rdata_r    <= data_mem[req_i.idx];
    end
  end

  // Tag compare happens in the result cycle against the registered request
  assign hit_o   = rd_valid_r & (rd_tag_r == req_tag_r);
  assign rdata_o = rdata_r;

endmodule

//--- test/fe_checker.sv
// ============================================================
// Front end checker, models cache contents and fetch order
// Watches the DUT ports and compares every delivered message
// ============================================================
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fe_checker
  import fe_pkg::*;
(
  input  logic            clk_i,
  input  logic            reset_i,
  input  logic [8*16-1:0] test_name_i,
  input  fe_cmd_s         fe_cmd_i,
  input  logic            fe_cmd_v_i,
  input  logic            fe_cmd_yumi_i,
  input  fe_queue_s       fe_queue_i,
  input  logic            fe_queue_v_i,
  input  logic            fe_queue_ready_i,
  output int unsigned     cmd_count_o,
  output int unsigned     msg_count_o,
  output int unsigned     check_count_o,
  output int unsigned     err_count_o
);

  // Words filled since the last fence, keyed by full address
  logic [`FE_INSTR_W-1:0] words [logic [`FE_VADDR_W-1:0]];
  logic                   expecting;
  logic [`FE_VADDR_W-1:0] exp_pc;
  fe_queue_s              exp_msg;

  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      words.delete();
      expecting     = 1'b0;
      exp_pc        = '0;
      cmd_count_o   = 0;
      msg_count_o   = 0;
      check_count_o = 0;
      err_count_o   = 0;
    end
    else
    begin
      if (fe_queue_v_i && !fe_queue_ready_i)
      begin
        err_count_o++;
        $display("Queue valid was raised while ready was low in %0s", test_name_i);
      end
      if (fe_queue_v_i && fe_queue_ready_i)
      begin
        msg_count_o++;
        if (!expecting)
        begin
          err_count_o++;
          $display("Unexpected queue message at pc %h in %0s after the run had ended",
                   fe_queue_i.pc, test_name_i);
        end
        else
        begin
          exp_msg    = '0;
          exp_msg.pc = exp_pc;
          if (words.exists(exp_pc))
          begin
            exp_msg.msg_type = e_msg_fetch;
            exp_msg.instr    = words[exp_pc];
            exp_pc           = exp_pc + 32'd4;
          end
          else
          begin
            // First unfilled address ends the run with one exception
            exp_msg.msg_type = e_msg_exception;
            expecting        = 1'b0;
          end
          check_count_o++;
          if (fe_queue_i !== exp_msg)
          begin
            err_count_o++;
            $display("FAIL %0s: expected type %0d pc %h instr %h, actual type %0d pc %h instr %h",
                     test_name_i, exp_msg.msg_type, exp_msg.pc, exp_msg.instr,
                     fe_queue_i.msg_type, fe_queue_i.pc, fe_queue_i.instr);
          end
        end
      end
      if (fe_cmd_yumi_i && !fe_cmd_v_i)
      begin
        err_count_o++;
        $display("A command was accepted in %0s with no valid command present", test_name_i);
      end
      if (fe_cmd_v_i && fe_cmd_yumi_i)
      begin
        cmd_count_o++;
        case (fe_cmd_i.opcode)
          e_op_redirect:
          begin
            expecting = 1'b1;
            exp_pc    = fe_cmd_i.vaddr;
          end
          e_op_fill:
          begin
            words[fe_cmd_i.vaddr] = fe_cmd_i.instr;
            expecting             = 1'b1;
            exp_pc                = fe_cmd_i.vaddr;
          end
          e_op_fence:
          begin
            words.delete();
            expecting = 1'b0;
          end
          default:
            expecting = 1'b0;
        endcase
      end
    end
  end

endmodule

//--- test/fe_tb.sv
// ============================================================
// Front end testbench, applies a table of command steps
// Each step sends one command and waits for its queue messages
// ============================================================
`timescale 1ns/1ps
`include "fe_cfg.svh"

module fe_tb
  import fe_pkg::*;
();

  localparam int unsigned cycles_per_msg_lp = 40;

  // Test names are exactly 16 characters so they fill the name field
  typedef struct packed {
    logic [8*16-1:0] name;
    logic            send;
    fe_cmd_s         cmd;
    int unsigned     msgs;
    int unsigned     quiet;
    logic            rand_ready;
  } step_s;

  logic            clk_i;
  logic            reset_i;
  fe_cmd_s         fe_cmd;
  logic            fe_cmd_v;
  logic            fe_cmd_yumi;
  fe_queue_s       fe_queue;
  logic            fe_queue_v;
  logic            fe_queue_ready;
  logic            rand_ready;
  logic [8*16-1:0] test_name;
  int unsigned     cmd_count;
  int unsigned     msg_count;
  int unsigned     check_count;
  int unsigned     err_count;
  int unsigned     cycle_count;
  int unsigned     cycle_limit;
  step_s           steps [$];

  fe_top fe_top_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_i         (fe_cmd),
    .fe_cmd_v_i       (fe_cmd_v),
    .fe_cmd_yumi_o    (fe_cmd_yumi),
    .fe_queue_o       (fe_queue),
    .fe_queue_v_o     (fe_queue_v),
    .fe_queue_ready_i (fe_queue_ready)
  );

  fe_checker fe_checker_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .test_name_i      (test_name),
    .fe_cmd_i         (fe_cmd),
    .fe_cmd_v_i       (fe_cmd_v),
    .fe_cmd_yumi_i    (fe_cmd_yumi),
    .fe_queue_i       (fe_queue),
    .fe_queue_v_i     (fe_queue_v),
    .fe_queue_ready_i (fe_queue_ready),
    .cmd_count_o      (cmd_count),
    .msg_count_o      (msg_count),
    .check_count_o    (check_count),
    .err_count_o      (err_count)
  );

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("Timeout after %0d cycles while running %0s", cycle_count, test_name);
      $display("Simulation FAILED");
      $finish;
    end
  end

  function automatic logic [`FE_INSTR_W-1:0] instr_for(logic [`FE_VADDR_W-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ 32'h0000_0013;
  endfunction

  function automatic step_s make_step(logic [8*16-1:0] name, logic send, fe_opcode_e op,
                                      logic [`FE_VADDR_W-1:0] vaddr, int unsigned msgs,
                                      int unsigned quiet, logic rnd);
    step_s s;
    s.name       = name;
    s.send       = send;
    s.cmd.opcode = op;
    s.cmd.vaddr  = vaddr;
    s.cmd.instr  = (op == e_op_fill) ? instr_for(vaddr) : '0;
    s.msgs       = msgs;
    s.quiet      = quiet;
    s.rand_ready = rnd;
    return s;
  endfunction

  // Four fills of consecutive words starting at base
  task automatic add_fills(logic [8*16-1:0] name, logic [`FE_VADDR_W-1:0] base, logic rnd);
    for (int k = 0; k < 4; k++)
      steps.push_back(make_step(name, 1'b1, e_op_fill, base + 32'(4 * k), 0, 0, rnd));
  endtask

  // Moves to the next falling edge and sets the queue ready level there
  task automatic next_cycle();
    @(negedge clk_i);
    if (rand_ready)
      fe_queue_ready = ($urandom % 3) != 0;
    else
      fe_queue_ready = 1'b1;
  endtask

  task automatic send_cmd(fe_cmd_s cmd);
    int unsigned base;
    base     = cmd_count;
    fe_cmd   = cmd;
    fe_cmd_v = 1'b1;
    while (cmd_count == base)
      next_cycle();
    fe_cmd_v = 1'b0;
  endtask

  task automatic await_msgs(int unsigned count);
    int unsigned target;
    target = msg_count + count;
    while (msg_count < target)
      next_cycle();
  endtask

  initial
  begin
    int unsigned tests_run;
    int unsigned test_errs;
    void'($urandom(32'ha399_c619));
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    fe_cmd         = '0;
    fe_cmd_v       = 1'b0;
    fe_queue_ready = 1'b1;
    rand_ready     = 1'b0;
    test_name      = '0;
    tests_run      = 0;

    steps.push_back(make_step("reset_idle_check", 1'b0, e_op_wait, '0, 0, 20, 1'b0));
    steps.push_back(make_step("redirect_to_miss", 1'b1, e_op_redirect, 32'h400, 1, 12, 1'b0));
    add_fills("fill_and_fetch_4", 32'h1000, 1'b0);
    steps.push_back(make_step("fill_and_fetch_4", 1'b1, e_op_redirect, 32'h1000, 5, 12, 1'b0));
    add_fills("random_ready_run", 32'h1000, 1'b1);
    steps.push_back(make_step("random_ready_run", 1'b1, e_op_redirect, 32'h1000, 5, 12, 1'b1));
    steps.push_back(make_step("fence_then_fetch", 1'b1, e_op_fence, '0, 0, 0, 1'b0));
    steps.push_back(make_step("fence_then_fetch", 1'b1, e_op_redirect, 32'h1000, 1, 12, 1'b0));
    add_fills("wait_stops_fetch", 32'h2000, 1'b0);
    steps.push_back(make_step("wait_stops_fetch", 1'b1, e_op_redirect, 32'h2000, 2, 0, 1'b0));
    steps.push_back(make_step("wait_stops_fetch", 1'b1, e_op_wait, '0, 0, 20, 1'b0));
    steps.push_back(make_step("wait_stops_fetch", 1'b1, e_op_redirect, 32'h2008, 3, 12, 1'b0));

    cycle_limit = 200;
    foreach (steps[i])
      cycle_limit += steps[i].msgs * cycles_per_msg_lp;

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    reset_i   = 1'b0;
    test_errs = err_count;

    for (int i = 0; i < steps.size(); i++)
    begin
      test_name  = steps[i].name;
      rand_ready = steps[i].rand_ready;
      if (steps[i].send)
        send_cmd(steps[i].cmd);
      await_msgs(steps[i].msgs);
      repeat (steps[i].quiet) next_cycle();
      // A test ends at its last step in the table
      if (i == steps.size() - 1 || steps[i+1].name != steps[i].name)
      begin
        $display("Test %0s finished with %0d errors", steps[i].name, err_count - test_errs);
        tests_run++;
        test_errs = err_count;
      end
    end

    $display("Tests %0d, checks %0d, errors %0d", tests_run, check_count, err_count);
    if (err_count == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule
